/* bench/wb_tb_table.svh */
/*
 * Writeback test table, one row per clock cycle
 * Columns: test name, ALU, load and jump inputs, branch, expected rf_write
 */
`ifndef WB_TB_TABLE_SVH
`define WB_TB_TABLE_SVH

    typedef struct {
        string             name;
        wb_pkg::wb_entry_t alu;
        wb_pkg::wb_entry_t load;
        wb_pkg::wb_entry_t jump;
        wb_pkg::branch_t   br;
        wb_pkg::wb_entry_t exp;     // Expected rf_write in this cycle
    } row_t;

    row_t rows[$];

    localparam wb_pkg::wb_entry_t NONE    = '0;
    localparam wb_pkg::branch_t   NO_BR   = 3'b000;
    localparam wb_pkg::branch_t   SPEC    = 3'b100;    // Branch unresolved
    localparam wb_pkg::branch_t   CORRECT = 3'b010;    // Spec drops with the outcome
    localparam wb_pkg::branch_t   MISPRED = 3'b001;

    // Valid result for register r with data derived from r so every write is traceable
    function automatic wb_pkg::wb_entry_t res(input int r);
        wb_pkg::wb_entry_t e;
        e.reg_en  = 1'b1;
        e.reg_sel = wb_pkg::reg_sel_t'(r);
        e.wdat    = wb_pkg::word_t'(32'hC0DE_0000) + wb_pkg::word_t'(r) * 32'h0101;
        return e;
    endfunction

    function automatic void add_row(input string name, input wb_pkg::wb_entry_t alu,
                                    input wb_pkg::wb_entry_t load,
                                    input wb_pkg::wb_entry_t jump,
                                    input wb_pkg::branch_t br, input wb_pkg::wb_entry_t exp);
        row_t r;
        r.name = name;
        r.alu  = alu;
        r.load = load;
        r.jump = jump;
        r.br   = br;
        r.exp  = exp;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row("idle_bypass",   res(1),  NONE,    NONE,    NO_BR,   res(1));
        add_row("idle_bypass",   NONE,    res(2),  NONE,    NO_BR,   res(2));
        add_row("idle_bypass",   NONE,    NONE,    NONE,    NO_BR,   NONE);
        // Load goes straight through and ALU drains next cycle
        add_row("alu_load_same", res(3),  res(4),  NONE,    NO_BR,   res(4));
        add_row("alu_load_same", NONE,    NONE,    NONE,    NO_BR,   res(3));
        add_row("alu_load_same", NONE,    NONE,    NONE,    NO_BR,   NONE);
        // ALU 5 waits in its buffer while the jump takes the port
        add_row("jump_priority", res(5),  res(6),  NONE,    NO_BR,   res(6));
        add_row("jump_priority", NONE,    res(8),  res(7),  NO_BR,   res(7));
        add_row("jump_priority", NONE,    res(9),  NONE,    NO_BR,   res(8));   // Tie with turn low
        add_row("jump_priority", NONE,    NONE,    NONE,    NO_BR,   res(5));   // Tie with turn high
        add_row("jump_priority", NONE,    NONE,    NONE,    NO_BR,   res(9));
        add_row("jump_priority", NONE,    NONE,    NONE,    NO_BR,   NONE);
        // Jumps block drains so both buffers fill before ties alternate
        add_row("round_robin",   res(10), res(11), NONE,    NO_BR,   res(11));
        add_row("round_robin",   NONE,    res(13), res(12), NO_BR,   res(12));
        add_row("round_robin",   NONE,    res(15), res(14), NO_BR,   res(14));
        add_row("round_robin",   res(16), NONE,    NONE,    NO_BR,   res(13));
        add_row("round_robin",   NONE,    NONE,    NONE,    NO_BR,   res(10));
        add_row("round_robin",   NONE,    NONE,    NONE,    NO_BR,   res(15));
        add_row("round_robin",   NONE,    NONE,    NONE,    NO_BR,   res(16));
        add_row("round_robin",   NONE,    NONE,    NONE,    NO_BR,   NONE);
        // ALU held while spec is high; the outcome-cycle push commits too
        add_row("spec_commit",   res(17), NONE,    NONE,    SPEC,    NONE);
        add_row("spec_commit",   NONE,    res(18), NONE,    SPEC,    res(18));
        add_row("spec_commit",   res(19), res(20), NONE,    SPEC,    res(20));
        add_row("spec_commit",   NONE,    res(21), NONE,    SPEC,    res(21));
        add_row("spec_commit",   res(22), NONE,    NONE,    CORRECT, NONE);
        add_row("spec_commit",   NONE,    NONE,    NONE,    NO_BR,   res(17));
        add_row("spec_commit",   NONE,    NONE,    NONE,    NO_BR,   res(19));
        add_row("spec_commit",   NONE,    NONE,    NONE,    NO_BR,   res(22));
        add_row("spec_commit",   NONE,    NONE,    NONE,    NO_BR,   NONE);
        // Rollback discards 23, 24 and 26 so buffered 28 lands in their old slots
        add_row("mispredict",    res(23), NONE,    NONE,    SPEC,    NONE);
        add_row("mispredict",    res(24), NONE,    NONE,    SPEC,    NONE);
        add_row("mispredict",    NONE,    res(25), NONE,    SPEC,    res(25));
        add_row("mispredict",    res(26), NONE,    NONE,    MISPRED, NONE);
        add_row("mispredict",    res(27), NONE,    NONE,    NO_BR,   res(27));
        add_row("mispredict",    res(28), res(29), NONE,    NO_BR,   res(29));  // ALU buffered
        add_row("mispredict",    NONE,    NONE,    NONE,    NO_BR,   res(28));
        add_row("mispredict",    NONE,    NONE,    NONE,    NO_BR,   NONE);
    endfunction

`endif

/* bench/tb_writeback.sv */
/*
 * Testbench for the writeback stage
 * Table driven stimulus, entry and write count checks, watchdog, report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_writeback;

    logic              CLK = 1'b0;
    logic              nRST;
    wb_pkg::wb_entry_t alu_result;
    wb_pkg::wb_entry_t load_result;
    wb_pkg::wb_entry_t jump_result;
    wb_pkg::branch_t   branch;
    wb_pkg::wb_entry_t rf_write;

    int err_total;      // All failed checks
    int test_err;       // Failed checks in the running test
    int tests_pass;
    int tests_fail;

`include "wb_tb_table.svh"

    writeback_top dut_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .alu_result  (alu_result),
        .load_result (load_result),
        .jump_result (jump_result),
        .branch      (branch),
        .rf_write    (rf_write)
    );

    always #20 CLK = ~CLK;      // 40 ns period

    task automatic check_entry(input string name, input wb_pkg::wb_entry_t exp,
                               input wb_pkg::wb_entry_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected en=%0b reg=%0d wdat=%h actual en=%0b reg=%0d wdat=%h",
                     name, exp.reg_en, exp.reg_sel, exp.wdat,
                     act.reg_en, act.reg_sel, act.wdat);
            err_total++;
            test_err++;
        end
    endtask

    task automatic check_count(input string name, input wb_pkg::count_t exp,
                               input wb_pkg::count_t act);
        if (act !== exp) begin
            $display("MISMATCH %s write count expected %0d actual %0d", name, exp, act);
            err_total++;
            test_err++;
        end
    endtask

    // Allowance of one cycle per row plus margin for reset and drain
    initial begin : watchdog
        int unsigned limit_ns;
        #1;
        limit_ns = (rows.size() + 20) * 40;
        #(limit_ns);
        $display("Run timed out after %0d ns before all table rows were applied", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : run
        wb_pkg::count_t writes_seen;
        wb_pkg::count_t writes_exp;
        bit             last_of_test;

        nRST        = 1'b0;
        alu_result  = '0;
        load_result = '0;
        jump_result = '0;
        branch      = '0;
        err_total   = 0;
        test_err    = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        writes_seen = '0;
        writes_exp  = '0;
        build_table();

        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            if (i == 0 || rows[i].name != rows[i-1].name) begin
                writes_seen = '0;   // New test starts
                writes_exp  = '0;
                test_err    = 0;
            end
            @(posedge CLK);
            alu_result  <= rows[i].alu;
            load_result <= rows[i].load;
            jump_result <= rows[i].jump;
            branch      <= rows[i].br;
            @(negedge CLK);     // rf_write settled mid cycle
            check_entry(rows[i].name, rows[i].exp, rf_write);
            if (rows[i].exp.reg_en) writes_exp++;
            if (rf_write.reg_en) writes_seen++;
            last_of_test = (i == rows.size() - 1) || (rows[i+1].name != rows[i].name);
            if (last_of_test) begin
                check_count(rows[i].name, writes_exp, writes_seen);
                if (test_err == 0) begin
                    tests_pass++;
                    $display("test %s passed, %0d writes", rows[i].name, writes_seen);
                end else begin
                    tests_fail++;
                    $display("test %s failed with %0d errors", rows[i].name, test_err);
                end
            end
        end

        $display("tests passed %0d, tests failed %0d", tests_pass, tests_fail);
        if (err_total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/result_fifo.sv */
/*
 * Circular buffer for load results, drained in arrival order
 * Head is shown combinationally, ready while not empty
 */
`timescale 1ns/1ps
`default_nettype none
`include "wb_cfg.svh"

module result_fifo (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              push,
    input  wb_pkg::wb_entry_t      din,
    input  wire logic              pop,
    output wb_pkg::wb_entry_t      head,
    output logic                   ready
);

    localparam wb_pkg::count_t FULL = wb_pkg::count_t'(`WB_BUF_DEPTH);

    wb_pkg::wb_entry_t mem [`WB_BUF_DEPTH];  // Payload storage
    wb_pkg::ptr_t      rptr, wptr;
    wb_pkg::count_t    count;                // Occupancy

    assign head  = mem[rptr];                // Oldest entry
    assign ready = (count != '0);

    // Payload write, no reset needed
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wptr] <= din;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            if (push) wptr <= wb_pkg::next_ptr(wptr);
            if (pop) rptr <= wb_pkg::next_ptr(rptr);
            // Simultaneous push and pop leaves count alone
            count <= count + wb_pkg::count_t'(push) - wb_pkg::count_t'(pop);
        end
    end

    // Arbiter must never overrun the buffer
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(push && !pop && count == FULL))
        else $error("load buffer push while full");

    // Arbiter pops only a ready head
    a_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(pop && count == '0))
        else $error("load buffer pop while empty");

endmodule

`default_nettype wire

/* hw/spec_fifo.sv */
/*
 * Circular buffer for ALU results with branch speculation
 * Checkpoints the write pointer when spec rises, commits on correct,
 * rolls back on mispredict; only committed entries may drain
 */
`timescale 1ns/1ps
`default_nettype none
`include "wb_cfg.svh"

module spec_fifo (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              push,
    input  wb_pkg::wb_entry_t      din,
    input  wire logic              pop,
    input  wb_pkg::branch_t        branch,
    output wb_pkg::wb_entry_t      head,
    output logic                   ready,
    output logic                   spec_now
);

    localparam wb_pkg::count_t FULL = wb_pkg::count_t'(`WB_BUF_DEPTH);

    typedef enum logic {
        S_IDLE,
        S_SPEC
    } state_t;

    wb_pkg::wb_entry_t mem [`WB_BUF_DEPTH];
    wb_pkg::ptr_t      rptr, wptr, wptr_nxt;
    wb_pkg::ptr_t      chk_wptr, chk_nxt;           // Write pointer at spec start
    wb_pkg::count_t    count, count_nxt;            // All entries
    wb_pkg::count_t    commit_cnt, commit_nxt;      // Entries allowed to drain
    wb_pkg::count_t    spec_cnt, spec_cnt_nxt;      // Pushes since spec start
    state_t            state, state_nxt;
    logic              prev_spec;
    logic              spec_rise;

    assign spec_rise = branch.spec && !prev_spec;
    assign spec_now  = spec_rise || (state == S_SPEC);  // Push now counts as speculative
    assign ready     = (commit_cnt != '0);
    assign head      = mem[rptr];

    always_comb begin
        state_nxt    = state;
        chk_nxt      = chk_wptr;
        spec_cnt_nxt = spec_cnt;
        wptr_nxt     = push ? wb_pkg::next_ptr(wptr) : wptr;
        count_nxt    = count + wb_pkg::count_t'(push) - wb_pkg::count_t'(pop);
        commit_nxt   = commit_cnt + wb_pkg::count_t'(push && !spec_now)
                       - wb_pkg::count_t'(pop);
        case (state)
            S_IDLE: begin
                if (spec_rise) begin
                    state_nxt    = S_SPEC;
                    chk_nxt      = wptr;        // Everything from here is speculative
                    spec_cnt_nxt = wb_pkg::count_t'(push);
                end
            end
            S_SPEC: begin
                if (branch.correct) begin
                    // Speculative entries plus this cycle's push become committed
                    state_nxt    = S_IDLE;
                    spec_cnt_nxt = '0;
                    commit_nxt   = commit_cnt + spec_cnt + wb_pkg::count_t'(push)
                                   - wb_pkg::count_t'(pop);
                end else if (branch.mispredict) begin
                    state_nxt    = S_IDLE;
                    spec_cnt_nxt = '0;
                    wptr_nxt     = chk_wptr;    // Drop spec entries and this push
                    count_nxt    = count - spec_cnt - wb_pkg::count_t'(pop);
                end else begin
                    spec_cnt_nxt = spec_cnt + wb_pkg::count_t'(push);
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wptr] <= din;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= S_IDLE;
            prev_spec  <= 1'b0;
            rptr       <= '0;
            wptr       <= '0;
            chk_wptr   <= '0;
            count      <= '0;
            commit_cnt <= '0;
            spec_cnt   <= '0;
        end else begin
            state      <= state_nxt;
            prev_spec  <= branch.spec;
            rptr       <= pop ? wb_pkg::next_ptr(rptr) : rptr;
            wptr       <= wptr_nxt;
            chk_wptr   <= chk_nxt;
            count      <= count_nxt;
            commit_cnt <= commit_nxt;
            spec_cnt   <= spec_cnt_nxt;
        end
    end

    // Speculative entries must never reach the register file
    a_pop_committed: assert property (@(posedge CLK) disable iff (!nRST)
        pop |-> (commit_cnt != '0))
        else $error("ALU buffer pop without committed entry");

    a_outcome_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        !(branch.correct && branch.mispredict))
        else $error("branch correct and mispredict together");

    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(push && !pop && count == FULL))
        else $error("ALU buffer push while full");

endmodule

`default_nettype wire

/* hw/wb_arbiter.sv */
/*
 * Register file write port arbiter
 * Jump first, then direct bypass when nothing drains, else round robin drain
 */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wb_pkg::wb_entry_t      alu_in,
    input  wb_pkg::wb_entry_t      load_in,
    input  wb_pkg::wb_entry_t      jump_in,
    input  wb_pkg::wb_entry_t      alu_head,
    input  wb_pkg::wb_entry_t      load_head,
    input  wire logic              alu_ready,
    input  wire logic              load_ready,
    input  wire logic              alu_spec,
    output logic                   alu_push,
    output logic                   load_push,
    output logic                   alu_pop,
    output logic                   load_pop,
    output wb_pkg::wb_entry_t      rf_write
);

    logic turn, turn_nxt;   // Low gives the load head the next tie

    always_comb begin
        alu_push  = 1'b0;
        load_push = 1'b0;
        alu_pop   = 1'b0;
        load_pop  = 1'b0;
        rf_write  = '0;
        turn_nxt  = turn;

        if (jump_in.reg_en) begin
            // Jump bypasses both buffers
            rf_write  = jump_in;
            load_push = load_in.reg_en;
        end else if (!alu_ready && !load_ready) begin
            // Nothing to drain, results may go straight through
            if (load_in.reg_en) begin
                rf_write = load_in;
                alu_push = alu_in.reg_en;   // ALU waits its turn
            end else if (alu_in.reg_en) begin
                if (alu_spec) begin
                    alu_push = 1'b1;        // Held until branch resolves
                end else begin
                    rf_write = alu_in;
                end
            end
        end else begin
            // Older entries waiting, new results queue behind them
            alu_push  = alu_in.reg_en;
            load_push = load_in.reg_en;
            if (alu_ready && load_ready) begin
                turn_nxt = !turn;
                if (turn) begin
                    alu_pop  = 1'b1;
                    rf_write = alu_head;
                end else begin
                    load_pop = 1'b1;
                    rf_write = load_head;
                end
            end else if (alu_ready) begin
                alu_pop  = 1'b1;
                rf_write = alu_head;
            end else begin
                load_pop = 1'b1;
                rf_write = load_head;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            turn <= 1'b0;
        end else begin
            turn <= turn_nxt;
        end
    end

    // Issue never completes a jump and an ALU op in one cycle
    a_jump_alu_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(jump_in.reg_en && alu_in.reg_en))
        else $error("jump and ALU results valid together");

endmodule

`default_nettype wire

/* hw/wb_cfg.svh */
/*
 * Writeback stage configuration macros
 * Register index width, data width and result buffer depth
 */
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// Destination register index width
`define WB_REG_SEL_W 5

// Register file data width
`define WB_DATA_W 32

// Entries per result buffer, same for ALU and load
`define WB_BUF_DEPTH 8

`endif

/* hw/wb_pkg.sv */
/*
 * Writeback types: result entry, branch status, buffer pointer and count
 * Pointer increment with wrap for the circular buffers
 */
`default_nettype none

package wb_pkg;
`include "wb_cfg.svh"

    localparam int PTR_W = (`WB_BUF_DEPTH > 1) ? $clog2(`WB_BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(`WB_BUF_DEPTH + 1);   // Holds 0 through depth

    typedef logic [`WB_REG_SEL_W-1:0] reg_sel_t;
    typedef logic [`WB_DATA_W-1:0]    word_t;

    typedef struct packed {
        logic     reg_en;   // Valid on inputs, write strobe on rf_write
        reg_sel_t reg_sel;
        word_t    wdat;
    } wb_entry_t;

    typedef struct packed {
        logic spec;         // Level, branch unresolved
        logic correct;      // Pulse
        logic mispredict;   // Pulse
    } branch_t;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    // Circular increment, wraps at the last slot
    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(`WB_BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

endpackage

`default_nettype wire

/* hw/writeback_top.sv */
/*
 * Writeback stage top
 * ALU spec buffer, load buffer and write port arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_top (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wb_pkg::wb_entry_t      alu_result,
    input  wb_pkg::wb_entry_t      load_result,
    input  wb_pkg::wb_entry_t      jump_result,
    input  wb_pkg::branch_t        branch,
    output wb_pkg::wb_entry_t      rf_write
);

    logic              alu_push, load_push;
    logic              alu_pop, load_pop;
    logic              alu_ready, load_ready;
    logic              alu_spec;        // ALU push this cycle is speculative
    wb_pkg::wb_entry_t alu_head, load_head;

    // ALU results, speculation aware
    spec_fifo alu_buf_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .push     (alu_push),
        .din      (alu_result),
        .pop      (alu_pop),
        .branch   (branch),
        .head     (alu_head),
        .ready    (alu_ready),
        .spec_now (alu_spec)
    );

    // Load results
    result_fifo load_buf_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .push  (load_push),
        .din   (load_result),
        .pop   (load_pop),
        .head  (load_head),
        .ready (load_ready)
    );

    wb_arbiter arb_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .alu_in     (alu_result),
        .load_in    (load_result),
        .jump_in    (jump_result),
        .alu_head   (alu_head),
        .load_head  (load_head),
        .alu_ready  (alu_ready),
        .load_ready (load_ready),
        .alu_spec   (alu_spec),
        .alu_push   (alu_push),
        .load_push  (load_push),
        .alu_pop    (alu_pop),
        .load_pop   (load_pop),
        .rf_write   (rf_write)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the writeback testbench, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_writeback -f sources.f &&
./obj_dir/Vtb_writeback | tee /dev/stderr | grep -qF "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+hw
+incdir+bench
hw/wb_pkg.sv
hw/result_fifo.sv
hw/spec_fifo.sv
hw/wb_arbiter.sv
hw/writeback_top.sv
bench/tb_writeback.sv
